// ==== include/decode_consts.svh ====
/*
 * Constants for the 6502 decode ROM model: opcode values, status bit
 * positions, RW pin levels and timing states. Included by the RTL and
 * the testbench wherever these values are compared or driven.
 */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// register-implied
`define OP_INX      8'hE8
`define OP_INY      8'hC8
`define OP_DEX      8'hCA
`define OP_DEY      8'h88
`define OP_ASL_A    8'h0A
`define OP_LSR_A    8'h4A
`define OP_ROL_A    8'h2A
`define OP_ROR_A    8'h6A

// flag set and clear
`define OP_SEC      8'h38
`define OP_CLC      8'h18
`define OP_SEI      8'h78
`define OP_CLI      8'h58
`define OP_CLV      8'hB8

// immediate operand
`define OP_LDA_IMM  8'hA9
`define OP_LDX_IMM  8'hA2
`define OP_LDY_IMM  8'hA0
`define OP_AND_IMM  8'h29
`define OP_EOR_IMM  8'h49
`define OP_ORA_IMM  8'h09
`define OP_ADC_IMM  8'h69
`define OP_SBC_IMM  8'hE9
`define OP_CMP_IMM  8'hC9
`define OP_CPX_IMM  8'hE0
`define OP_CPY_IMM  8'hC0

// transfers and NOP
`define OP_TAX      8'hAA
`define OP_TAY      8'hA8
`define OP_TXA      8'h8A
`define OP_TYA      8'h98
`define OP_TXS      8'h9A
`define OP_TSX      8'hBA
`define OP_NOP      8'hEA

// conditional branches
`define OP_BPL      8'h10
`define OP_BMI      8'h30
`define OP_BVC      8'h50
`define OP_BVS      8'h70
`define OP_BCC      8'h90
`define OP_BCS      8'hB0
`define OP_BNE      8'hD0
`define OP_BEQ      8'hF0

// absolute addressing
`define OP_LDA_ABS  8'hAD
`define OP_LDX_ABS  8'hAE
`define OP_LDY_ABS  8'hAC
`define OP_STA_ABS  8'h8D
`define OP_STX_ABS  8'h8E
`define OP_STY_ABS  8'h8C

// bit positions in P
`define FLAG_C      0
`define FLAG_Z      1
`define FLAG_V      6
`define FLAG_N      7

`define RW_READ     1'b1
`define RW_WRITE    1'b0

`define TCU_W       4
`define T0          4'd0
`define T1          4'd1
`define T2          4'd2
`define T3          4'd3

`endif

// ==== source/decode_pkg.sv ====
/*
 * Types shared by the decode ROM stages: the decoded opcode summary
 * and the datapath control word, grouped by the part of the datapath
 * each line drives.
 */
package decode_pkg;

    typedef enum logic [3:0] {
        IMPLIED_REG, FLAG_OP, LOAD_IMM, ALU_IMM, TRANSFER,
        BRANCH, LOAD_ABS, STORE_ABS, NOP_OP, ILLEGAL
    } op_class_t;

    // for FLAG_OP the destination names the flag: AC is C, X is I, Y is V
    typedef enum logic [1:0] {
        AC, X, Y, S
    } reg_sel_t;

    typedef enum logic [3:0] {
        INC, DEC, LSR, ASL, ROR, ROL,
        AND, EOR, ORA, ADC, SBC, CMP
    } alu_op_t;

    typedef struct packed {
        op_class_t op_class;
        reg_sel_t  src;
        reg_sel_t  dst;
        alu_op_t   alu_op;
        logic      upd_zn;
    } op_info_t;

    typedef struct packed {
        logic pcl_pcl, pch_pch, i_pc;
        logic adl_pcl, adh_pch;
        logic pcl_adl, pch_adh, pch_db;
    } pc_ctrl_t;

    typedef struct packed {
        logic x_sb, y_sb, ac_sb, ac_db, s_sb;
        logic sb_x, sb_y, sb_ac, sb_s;
        logic sb_db, dl_db, sb_adh;
    } reg_ctrl_t;

    // ALU input select, operation and output enables
    typedef struct packed {
        logic db_add, db_n_add, adl_add, sb_add, zero_add, one_addc;
        logic sums, ands, eors, ors, srs;
        logic add_sb, add_adl;
    } alu_ctrl_t;

    typedef struct packed {
        logic dbz_z, db7_n;
        logic acr_c, ir5_c, ir5_i, avr_v;
    } flag_ctrl_t;

    typedef struct packed {
        logic rw;
        logic adl_abl, adh_abh, dl_adh;
    } bus_ctrl_t;

    typedef struct packed {
        pc_ctrl_t   pc;
        reg_ctrl_t  regs;
        alu_ctrl_t  alu;
        flag_ctrl_t flags;
        bus_ctrl_t  bus;
    } ctrl_word_t;

endpackage

// ==== source/opcode_classifier.sv ====
/*
 * Sorts the instruction register into an opcode class with its source
 * and destination registers and ALU operation. Unknown opcodes come out
 * as ILLEGAL.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module opcode_classifier
(
    input  logic [7:0]           i_ir,
    output decode_pkg::op_info_t o_info
);

    always_comb
    begin
        case (i_ir)
            `OP_INX, `OP_INY, `OP_DEX, `OP_DEY,
            `OP_ASL_A, `OP_LSR_A, `OP_ROL_A, `OP_ROR_A:
                o_info.op_class = decode_pkg::IMPLIED_REG;
            `OP_SEC, `OP_CLC, `OP_SEI, `OP_CLI, `OP_CLV:
                o_info.op_class = decode_pkg::FLAG_OP;
            `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM:
                o_info.op_class = decode_pkg::LOAD_IMM;
            `OP_AND_IMM, `OP_EOR_IMM, `OP_ORA_IMM, `OP_ADC_IMM,
            `OP_SBC_IMM, `OP_CMP_IMM, `OP_CPX_IMM, `OP_CPY_IMM:
                o_info.op_class = decode_pkg::ALU_IMM;
            `OP_TAX, `OP_TAY, `OP_TXA, `OP_TYA, `OP_TXS, `OP_TSX:
                o_info.op_class = decode_pkg::TRANSFER;
            `OP_BPL, `OP_BMI, `OP_BVC, `OP_BVS,
            `OP_BCC, `OP_BCS, `OP_BNE, `OP_BEQ:
                o_info.op_class = decode_pkg::BRANCH;
            `OP_LDA_ABS, `OP_LDX_ABS, `OP_LDY_ABS:
                o_info.op_class = decode_pkg::LOAD_ABS;
            `OP_STA_ABS, `OP_STX_ABS, `OP_STY_ABS:
                o_info.op_class = decode_pkg::STORE_ABS;
            `OP_NOP:
                o_info.op_class = decode_pkg::NOP_OP;
            default:
                o_info.op_class = decode_pkg::ILLEGAL;
        endcase

        // register driven onto SB or DB
        case (i_ir)
            `OP_INX, `OP_DEX, `OP_TXA, `OP_TXS, `OP_CPX_IMM, `OP_STX_ABS:
                o_info.src = decode_pkg::X;
            `OP_INY, `OP_DEY, `OP_TYA, `OP_CPY_IMM, `OP_STY_ABS:
                o_info.src = decode_pkg::Y;
            `OP_TSX:
                o_info.src = decode_pkg::S;
            default:
                o_info.src = decode_pkg::AC;
        endcase

        // register loaded from SB, or the flag a flag op changes
        case (i_ir)
            `OP_INX, `OP_DEX, `OP_TAX, `OP_TSX, `OP_LDX_IMM, `OP_LDX_ABS,
            `OP_SEI, `OP_CLI:
                o_info.dst = decode_pkg::X;
            `OP_INY, `OP_DEY, `OP_TAY, `OP_LDY_IMM, `OP_LDY_ABS, `OP_CLV:
                o_info.dst = decode_pkg::Y;
            `OP_TXS:
                o_info.dst = decode_pkg::S;
            default:
                o_info.dst = decode_pkg::AC;
        endcase

        case (i_ir)
            `OP_INX, `OP_INY: o_info.alu_op = decode_pkg::INC;
            `OP_DEX, `OP_DEY: o_info.alu_op = decode_pkg::DEC;
            `OP_LSR_A:        o_info.alu_op = decode_pkg::LSR;
            `OP_ASL_A:        o_info.alu_op = decode_pkg::ASL;
            `OP_ROR_A:        o_info.alu_op = decode_pkg::ROR;
            `OP_ROL_A:        o_info.alu_op = decode_pkg::ROL;
            `OP_AND_IMM:      o_info.alu_op = decode_pkg::AND;
            `OP_EOR_IMM:      o_info.alu_op = decode_pkg::EOR;
            `OP_ORA_IMM:      o_info.alu_op = decode_pkg::ORA;
            `OP_SBC_IMM:      o_info.alu_op = decode_pkg::SBC;
            `OP_CMP_IMM, `OP_CPX_IMM, `OP_CPY_IMM:
                o_info.alu_op = decode_pkg::CMP;
            default:
                o_info.alu_op = decode_pkg::ADC;
        endcase

        // Z and N follow any value written to a register, except into S
        o_info.upd_zn = (i_ir != `OP_TXS) &&
                        (o_info.op_class inside {decode_pkg::IMPLIED_REG,
                                                 decode_pkg::LOAD_IMM,
                                                 decode_pkg::ALU_IMM,
                                                 decode_pkg::TRANSFER,
                                                 decode_pkg::LOAD_ABS});
    end

endmodule

// ==== source/branch_evaluator.sv ====
/*
 * Branch condition test and the registered ALU carry. IR bits 7:6 pick
 * the flag and IR bit 5 the value that takes the branch.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module branch_evaluator
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [7:0] i_ir,
    input  logic [7:0] i_p,
    input  logic       i_acr,
    output logic       o_taken,
    output logic       o_last_acr
);

    logic tested_flag;

    always_comb
    begin
        case (i_ir[7:6])
            2'b00:   tested_flag = i_p[`FLAG_N];
            2'b01:   tested_flag = i_p[`FLAG_V];
            2'b10:   tested_flag = i_p[`FLAG_C];
            default: tested_flag = i_p[`FLAG_Z];
        endcase
    end

    assign o_taken = (tested_flag == i_ir[5]);

    // carry out of the offset add, needed one cycle later for the page cross
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_last_acr <= 1'b0;
        else
            o_last_acr <= i_acr;
    end

endmodule

// ==== source/cycle_sequencer.sv ====
/*
 * Next timing count for the decode ROM. Returns to T0 at the last state
 * of each instruction and stalls with an error flag on unknown opcodes.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module cycle_sequencer
(
    input  decode_pkg::op_info_t i_info,
    input  logic [`TCU_W-1:0]    i_tcu,
    input  logic                 i_taken,
    input  logic                 i_last_acr,
    output logic [`TCU_W-1:0]    o_tcu,
    output logic                 o_error
);

    always_comb
    begin
        o_tcu = i_tcu + `TCU_W'(1);
        o_error = 1'b0;

        case (i_info.op_class)
            decode_pkg::LOAD_ABS, decode_pkg::STORE_ABS:
            begin
                if (i_tcu == `T3)
                    o_tcu = `T0;
            end
            decode_pkg::BRANCH:
            begin
                // untaken ends at T1, taken at T2 unless the page was crossed
                if ((i_tcu == `T1 && !i_taken) ||
                    (i_tcu == `T2 && !i_last_acr) ||
                    (i_tcu == `T3))
                    o_tcu = `T0;
            end
            decode_pkg::ILLEGAL:
            begin
                if (i_tcu == `T1)
                begin
                    o_tcu = i_tcu;
                    o_error = 1'b1;
                end
            end
            default:
            begin
                // one-byte and immediate opcodes
                if (i_tcu == `T1)
                    o_tcu = `T0;
            end
        endcase
    end

endmodule

// ==== source/control_word_gen.sv ====
/*
 * Datapath control word for the current opcode class and timing state.
 * T0 fetches the next opcode and finishes a pending register write;
 * T1 to T3 carry the per-class bus moves.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module control_word_gen
(
    input  decode_pkg::op_info_t   i_info,
    input  logic [`TCU_W-1:0]      i_tcu,
    input  logic [7:0]             i_p,
    input  logic                   i_taken,
    input  logic                   i_last_acr,
    output decode_pkg::ctrl_word_t o_ctrl
);

    decode_pkg::ctrl_word_t w;
    logic pc_on_ab;
    logic hold_pc;
    logic load_dst;
    logic drive_src;
    logic logic_op;
    logic cmp_only;

    assign logic_op = i_info.alu_op inside {decode_pkg::AND, decode_pkg::EOR, decode_pkg::ORA};
    assign cmp_only = (i_info.op_class == decode_pkg::ALU_IMM) &&
                      (i_info.alu_op == decode_pkg::CMP);

    always_comb
    begin
        w = '0;
        w.bus.rw = `RW_READ;
        pc_on_ab = 1'b0;
        hold_pc = 1'b0;
        load_dst = 1'b0;
        drive_src = 1'b0;

        case (i_tcu)
            `T0:
            begin
                pc_on_ab = 1'b1;
                hold_pc = 1'b1;
                w.pc.i_pc = 1'b1;
                // result of the previous opcode still sits in the ALU
                if (i_info.op_class inside {decode_pkg::IMPLIED_REG, decode_pkg::ALU_IMM,
                                            decode_pkg::LOAD_ABS})
                begin
                    w.alu.add_sb = 1'b1;
                    w.regs.sb_db = 1'b1;
                    w.flags.dbz_z = i_info.upd_zn;
                    w.flags.db7_n = i_info.upd_zn;
                    load_dst = !cmp_only;
                end
            end
            `T1:
            begin
                if (i_info.op_class != decode_pkg::ILLEGAL)
                begin
                    pc_on_ab = 1'b1;
                    hold_pc = 1'b1;
                end
                case (i_info.op_class)
                    decode_pkg::IMPLIED_REG:
                    begin
                        drive_src = 1'b1;
                        w.alu.sb_add = 1'b1;
                        case (i_info.alu_op)
                            decode_pkg::INC:
                            begin
                                // inverted precharge gives 0, carry in adds one
                                w.alu.db_n_add = 1'b1;
                                w.alu.one_addc = 1'b1;
                                w.alu.sums = 1'b1;
                            end
                            decode_pkg::DEC:
                            begin
                                w.alu.db_add = 1'b1;
                                w.alu.sums = 1'b1;
                            end
                            decode_pkg::LSR, decode_pkg::ROR:
                            begin
                                w.alu.srs = 1'b1;
                                w.flags.acr_c = 1'b1;
                            end
                            default:
                            begin
                                // shift left as AC plus AC
                                w.regs.sb_db = 1'b1;
                                w.alu.db_add = 1'b1;
                                w.alu.sums = 1'b1;
                                w.flags.acr_c = 1'b1;
                            end
                        endcase
                        if (i_info.alu_op inside {decode_pkg::ROR, decode_pkg::ROL})
                            w.alu.one_addc = i_p[`FLAG_C];
                    end
                    decode_pkg::FLAG_OP:
                    begin
                        case (i_info.dst)
                            decode_pkg::AC: w.flags.ir5_c = 1'b1;
                            decode_pkg::X:  w.flags.ir5_i = 1'b1;
                            default:        w.flags.avr_v = 1'b1;
                        endcase
                    end
                    decode_pkg::LOAD_IMM:
                    begin
                        w.pc.i_pc = 1'b1;
                        w.regs.dl_db = 1'b1;
                        w.regs.sb_db = 1'b1;
                        w.flags.dbz_z = i_info.upd_zn;
                        w.flags.db7_n = i_info.upd_zn;
                        load_dst = 1'b1;
                    end
                    decode_pkg::ALU_IMM:
                    begin
                        w.pc.i_pc = 1'b1;
                        w.regs.dl_db = 1'b1;
                        drive_src = 1'b1;
                        w.alu.sb_add = 1'b1;
                        case (i_info.alu_op)
                            decode_pkg::AND: w.alu.ands = 1'b1;
                            decode_pkg::EOR: w.alu.eors = 1'b1;
                            decode_pkg::ORA: w.alu.ors = 1'b1;
                            decode_pkg::ADC: w.alu.one_addc = i_p[`FLAG_C];
                            decode_pkg::SBC: w.alu.one_addc = !i_p[`FLAG_C];
                            default:         w.alu.one_addc = 1'b1;
                        endcase
                        // subtract and compare add the inverted operand
                        w.alu.db_n_add = i_info.alu_op inside {decode_pkg::SBC, decode_pkg::CMP};
                        w.alu.db_add = !w.alu.db_n_add;
                        w.alu.sums = !logic_op;
                        w.flags.acr_c = !logic_op;
                        w.flags.avr_v = !logic_op;
                    end
                    decode_pkg::TRANSFER:
                    begin
                        drive_src = 1'b1;
                        load_dst = 1'b1;
                        w.regs.sb_db = i_info.upd_zn;
                        w.flags.dbz_z = i_info.upd_zn;
                        w.flags.db7_n = i_info.upd_zn;
                    end
                    decode_pkg::BRANCH:
                    begin
                        if (i_taken)
                        begin
                            // PCL + 1 + offset from DL
                            w.alu.adl_add = 1'b1;
                            w.alu.one_addc = 1'b1;
                            w.alu.sums = 1'b1;
                            w.regs.dl_db = 1'b1;
                            w.regs.sb_db = 1'b1;
                            w.alu.sb_add = 1'b1;
                        end
                        else
                            w.pc.i_pc = 1'b1;
                    end
                    decode_pkg::LOAD_ABS, decode_pkg::STORE_ABS:
                    begin
                        // low address byte into ADD
                        w.pc.i_pc = 1'b1;
                        w.regs.dl_db = 1'b1;
                        w.alu.db_add = 1'b1;
                        w.alu.zero_add = 1'b1;
                        w.alu.sums = 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            end
            `T2:
            begin
                case (i_info.op_class)
                    decode_pkg::BRANCH:
                    begin
                        w.pc.pch_adh = 1'b1;
                        w.bus.adh_abh = 1'b1;
                        w.alu.add_adl = 1'b1;
                        w.bus.adl_abl = 1'b1;
                        w.pc.adl_pcl = 1'b1;
                        w.pc.pch_pch = 1'b1;
                        if (i_last_acr)
                        begin
                            // page crossed so PCH + 1
                            w.pc.pch_db = 1'b1;
                            w.alu.db_add = 1'b1;
                            w.alu.zero_add = 1'b1;
                            w.alu.one_addc = 1'b1;
                            w.alu.sums = 1'b1;
                        end
                    end
                    decode_pkg::LOAD_ABS, decode_pkg::STORE_ABS:
                    begin
                        // fetch the high byte, low byte kept circulating in ADD
                        pc_on_ab = 1'b1;
                        hold_pc = 1'b1;
                        w.alu.add_sb = 1'b1;
                        w.alu.sb_add = 1'b1;
                        w.alu.db_n_add = 1'b1;
                        w.alu.sums = 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            end
            `T3:
            begin
                case (i_info.op_class)
                    decode_pkg::BRANCH:
                    begin
                        w.pc.pch_adh = 1'b1;
                        w.bus.adh_abh = 1'b1;
                        w.pc.pcl_adl = 1'b1;
                        w.bus.adl_abl = 1'b1;
                        w.pc.pcl_pcl = 1'b1;
                        w.alu.add_sb = 1'b1;
                        w.regs.sb_adh = 1'b1;
                        w.pc.adh_pch = 1'b1;
                    end
                    decode_pkg::LOAD_ABS, decode_pkg::STORE_ABS:
                    begin
                        // effective address is ADD low, DL high
                        hold_pc = 1'b1;
                        w.pc.i_pc = 1'b1;
                        w.alu.add_adl = 1'b1;
                        w.bus.adl_abl = 1'b1;
                        w.bus.dl_adh = 1'b1;
                        w.bus.adh_abh = 1'b1;
                        if (i_info.op_class == decode_pkg::LOAD_ABS)
                        begin
                            w.regs.dl_db = 1'b1;
                            w.alu.db_add = 1'b1;
                            w.alu.zero_add = 1'b1;
                            w.alu.sums = 1'b1;
                        end
                        else
                        begin
                            w.bus.rw = `RW_WRITE;
                            w.regs.ac_db = (i_info.src == decode_pkg::AC);
                            w.regs.sb_db = (i_info.src != decode_pkg::AC);
                            drive_src = (i_info.src != decode_pkg::AC);
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end
            default:
            begin
            end
        endcase

        if (pc_on_ab)
        begin
            w.pc.pcl_adl = 1'b1;
            w.pc.pch_adh = 1'b1;
            w.bus.adl_abl = 1'b1;
            w.bus.adh_abh = 1'b1;
        end
        if (hold_pc)
        begin
            w.pc.pcl_pcl = 1'b1;
            w.pc.pch_pch = 1'b1;
        end
        if (drive_src)
        begin
            case (i_info.src)
                decode_pkg::X: w.regs.x_sb = 1'b1;
                decode_pkg::Y: w.regs.y_sb = 1'b1;
                decode_pkg::S: w.regs.s_sb = 1'b1;
                default:       w.regs.ac_sb = 1'b1;
            endcase
        end
        if (load_dst)
        begin
            case (i_info.dst)
                decode_pkg::X: w.regs.sb_x = 1'b1;
                decode_pkg::Y: w.regs.sb_y = 1'b1;
                decode_pkg::S: w.regs.sb_s = 1'b1;
                default:       w.regs.sb_ac = 1'b1;
            endcase
        end
    end

    assign o_ctrl = w;

endmodule

// ==== source/decode_rom.sv ====
/*
 * Decode ROM top level. Maps IR, timing count and P to the control word,
 * the next timing count and an error flag, all within the same cycle.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module decode_rom
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [7:0]             i_ir,
    input  logic [`TCU_W-1:0]      i_tcu,
    input  logic [7:0]             i_p,
    input  logic                   i_acr,
    output logic [`TCU_W-1:0]      o_tcu,
    output logic                   o_error,
    output decode_pkg::ctrl_word_t o_ctrl
);

    decode_pkg::op_info_t info;
    logic taken;
    logic last_acr;

    opcode_classifier u_classifier
    (
        .i_ir   (i_ir),
        .o_info (info)
    );

    branch_evaluator u_branch
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ir       (i_ir),
        .i_p        (i_p),
        .i_acr      (i_acr),
        .o_taken    (taken),
        .o_last_acr (last_acr)
    );

    cycle_sequencer u_sequencer
    (
        .i_info     (info),
        .i_tcu      (i_tcu),
        .i_taken    (taken),
        .i_last_acr (last_acr),
        .o_tcu      (o_tcu),
        .o_error    (o_error)
    );

    control_word_gen u_ctrl_gen
    (
        .i_info     (info),
        .i_tcu      (i_tcu),
        .i_p        (i_p),
        .i_taken    (taken),
        .i_last_acr (last_acr),
        .o_ctrl     (o_ctrl)
    );

endmodule

// ==== tests/tb_decode_rom.sv ====
/*
 * Testbench for the decode ROM. Reads vectors from the pattern file,
 * drives one vector per clock and compares next tcu, error flag and
 * control word against the expected columns of the same line.
 */
`timescale 1ns/100ps
`include "decode_consts.svh"

module tb_decode_rom;

    localparam int MAX_LINES = 200;
    localparam int RESET_CYCLES = 3;
    localparam int WATCHDOG_NS = 20000;

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic [7:0]             i_ir;
    logic [`TCU_W-1:0]      i_tcu;
    logic [7:0]             i_p;
    logic                   i_acr;
    logic [`TCU_W-1:0]      o_tcu;
    logic                   o_error;
    decode_pkg::ctrl_word_t o_ctrl;

    int vector_num;

    decode_rom u_decode_rom
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ir    (i_ir),
        .i_tcu   (i_tcu),
        .i_p     (i_p),
        .i_acr   (i_acr),
        .o_tcu   (o_tcu),
        .o_error (o_error),
        .o_ctrl  (o_ctrl)
    );

    // 4 ns period
    always #2 i_clk = ~i_clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: vector %0d %s is %0h, expected %0h",
                     $time, vector_num, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Simulation ran past the watchdog limit without finishing");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int                fd;
        int                line_count;
        int                fields;
        int                cycle;
        logic              done;
        string             line_buf;
        logic [7:0]        ir_v;
        logic [11:0]       p_v;
        logic [`TCU_W-1:0] tcu_v;
        logic [`TCU_W-1:0] exp_tcu;
        logic              acr_v;
        logic              exp_err;
        logic [42:0]       exp_ctrl;

        void'($urandom(32'hd5e67512));
        i_rst_n = 1'b0;
        i_ir = `OP_NOP;
        i_tcu = `T0;
        i_p = 8'h00;
        i_acr = 1'b0;
        vector_num = 0;
        line_count = 0;
        done = 1'b0;

        fd = $fopen("tests/decode_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the pattern file tests/decode_patterns.txt");
            $display("** FAIL **");
            $fatal(1, "missing pattern file");
        end

        for (cycle = 0; cycle < RESET_CYCLES; cycle++)
            @(posedge i_clk);
        i_rst_n <= 1'b1;

        // lines that do not parse as seven fields are comments or blank
        while (!done && line_count < MAX_LINES)
        begin
            line_count++;
            if ($fgets(line_buf, fd) == 0)
                done = 1'b1;
            else
            begin
                fields = $sscanf(line_buf, "%h %h %h %h %h %h %h",
                                 ir_v, tcu_v, p_v, acr_v, exp_tcu, exp_err, exp_ctrl);
                if (fields == 7)
                begin
                    @(posedge i_clk);
                    i_ir <= ir_v;
                    i_tcu <= tcu_v;
                    // p of 100 means the vector does not depend on P
                    if (p_v == 12'h100)
                        i_p <= 8'($urandom % 256);
                    else
                        i_p <= p_v[7:0];
                    i_acr <= acr_v;
                    @(negedge i_clk);
                    vector_num++;
                    check_value(64'(o_tcu), 64'(exp_tcu), "o_tcu");
                    check_value(64'(o_error), 64'(exp_err), "o_error");
                    check_value(64'(o_ctrl), 64'(exp_ctrl), "o_ctrl");
                end
            end
        end
        $fclose(fd);

        if (!done)
        begin
            $display("Pattern file exceeded %0d lines before its end", MAX_LINES);
            $display("** FAIL **");
            $fatal(1, "pattern read limit reached");
        end
        else if (vector_num == 0)
        begin
            $display("No test vectors were found in the pattern file");
            $display("** FAIL **");
            $fatal(1, "empty pattern file");
        end
        else
        begin
            $display("%0d vectors checked", vector_num);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== tests/decode_patterns.txt ====
# columns: ir tcu p acr exp_tcu exp_error exp_ctrl, all hex
# p of 100 picks a random P; exp_ctrl is the 43-bit control word, pc group first
a9 1 100 0 0 0 7300B00030E
a2 1 100 0 0 0 7302300030E
29 1 100 0 0 0 7310148800E
69 1 001 0 0 0 731014B009E
69 1 000 0 0 0 7310149009E
e9 1 001 0 0 0 7310129009E
e9 1 000 0 0 0 731012B009E
e0 1 100 0 0 0 734012B009E
c9 0 100 0 1 0 73002000B0E
38 1 100 0 0 0 6300000004E
58 1 100 0 0 0 6300000002E
aa 1 100 0 0 0 6312200030E
9a 1 100 0 0 0 6340400000E
ea 1 100 0 0 0 6300000000E
e8 1 100 0 0 0 634002B000E
e8 0 100 0 1 0 73022000B0E
2a 1 001 0 0 0 631024B008E
4a 1 100 0 0 0 6310008108E
f0 1 000 0 0 0 7300000000E
f0 1 002 0 2 0 630031B000E
f0 2 100 0 0 0 2900000040E
90 1 000 1 2 0 630031B000E
90 2 100 0 3 0 2980047040E
90 3 100 0 0 0 4700080080E
8e 1 100 0 2 0 7300145000E
8e 2 100 0 3 0 6300029080E
8e 3 100 0 0 0 70402000407
8d 3 100 0 0 0 70080000407
ac 3 100 0 0 0 7000145040F
ac 0 100 0 1 0 73012000B0E
02 1 100 0 1 1 00000000008

// ==== filelist.f ====
+incdir+include
source/decode_pkg.sv
source/opcode_classifier.sv
source/branch_evaluator.sv
source/cycle_sequencer.sv
source/control_word_gen.sv
source/decode_rom.sv
tests/tb_decode_rom.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the decode ROM testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_decode_rom \
    -Mdir obj_dir -o tb_decode_rom > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_decode_rom > sim.log 2>&1
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"
